//--- logic/branch_tag_pkg.sv
`default_nettype none

package branch_tag_pkg;

    // Number of branches that may be in flight at once
    localparam int num_branch_tags = 4;

    // Width of a tag index into the branch stack
    localparam int tag_width = 2;

    // One bit per tag, used for busy sets and dependence masks
    typedef logic [num_branch_tags-1:0] branch_mask_t;

    // Index of a single branch tag
    typedef logic [tag_width-1:0] branch_tag_t;

    // Result reported by the completion stage for a branch
    typedef enum logic {
        resolve_correct    = 1'b0,
        resolve_mispredict = 1'b1
    } resolve_outcome_e;

endpackage

`default_nettype wire

//--- logic/checkpoint_pkg.sv
`default_nettype none

package checkpoint_pkg;

    localparam int pc_width            = 32;
    localparam int rob_index_width     = 5;
    localparam int num_phys_regs       = 32;
    localparam int num_arch_regs       = 8;
    localparam int phys_reg_idx_width  = $clog2(num_phys_regs);

    typedef logic [pc_width-1:0]           pc_t;
    typedef logic [rob_index_width-1:0]    rob_index_t;

    // One bit per physical register, set when the register is free
    typedef logic [num_phys_regs-1:0]      free_list_t;

    typedef logic [phys_reg_idx_width-1:0] phys_reg_idx_t;

    // Architectural to physical mapping, 8 entries of 5 bits
    typedef phys_reg_idx_t [num_arch_regs-1:0] map_table_t;

endpackage

`default_nettype wire

//--- logic/tag_allocator.sv
`timescale 1ns/100ps
`default_nettype none

module tag_allocator
    import branch_tag_pkg::*;
(
    input  wire logic         clock,
    input  wire logic         reset,
    input  wire logic         branch_valid,
    input  wire branch_mask_t clear_mask,
    input  wire logic         kill,
    output logic              branch_ready,
    output logic              grant,
    output branch_tag_t       grant_tag,
    output branch_mask_t      dispatch_mask,
    output branch_mask_t      live_mask
);

    branch_mask_t busy;
    branch_mask_t surviving;
    branch_mask_t grant_onehot;
    branch_tag_t  lowest_free;
    logic         any_free;

    // Tags released this cycle no longer count as busy
    assign surviving = busy & ~clear_mask;

    // Lowest zero bit of the surviving set
    always_comb begin
        lowest_free = '0;
        for (int i = num_branch_tags - 1; i >= 0; i--) begin
            if (!surviving[i]) begin
                lowest_free = branch_tag_t'(i);
            end
        end
    end

    // Readiness follows the registered busy set
    assign any_free = ~&busy;

    // No allocation while a mispredict is being recovered
    assign branch_ready = any_free && !kill;
    assign grant        = branch_valid && branch_ready;

    assign grant_tag     = lowest_free;
    assign dispatch_mask = surviving;
    assign live_mask     = busy;

    always_comb begin
        grant_onehot = '0;
        if (grant) begin
            grant_onehot[grant_tag] = 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            busy <= '0;
        end else begin
            busy <= surviving | grant_onehot;
        end
    end

endmodule

`default_nettype wire

//--- logic/branch_stack.sv
`timescale 1ns/100ps
`default_nettype none

module branch_stack
    import branch_tag_pkg::*, checkpoint_pkg::*;
(
    input  wire logic             clock,
    input  wire logic             reset,
    input  wire logic             grant,
    input  wire branch_tag_t      grant_tag,
    input  wire branch_mask_t     dispatch_mask,
    input  wire branch_mask_t     live_mask,
    input  wire pc_t              snap_pc,
    input  wire rob_index_t       snap_rob_tail,
    input  wire free_list_t       snap_free_list,
    input  wire map_table_t       snap_map_table,
    input  wire logic             resolve_valid,
    input  wire branch_tag_t      resolve_tag,
    input  wire resolve_outcome_e resolve_outcome,
    output branch_mask_t          clear_mask,
    output logic                  kill,
    output branch_mask_t          killed_mask,
    output pc_t                   sel_pc,
    output rob_index_t            sel_rob_tail,
    output free_list_t            sel_free_list,
    output map_table_t            sel_map_table
);

    pc_t          entry_pc        [num_branch_tags];
    rob_index_t   entry_rob_tail  [num_branch_tags];
    free_list_t   entry_free_list [num_branch_tags];
    map_table_t   entry_map_table [num_branch_tags];
    branch_mask_t entry_dep       [num_branch_tags];

    logic         resolve_hit;
    logic         correct;
    logic         mispredict;
    logic         recovering;
    branch_mask_t resolved_bit;
    branch_mask_t descendants;

    // A resolve of a free tag is ignored
    assign resolve_hit = resolve_valid && live_mask[resolve_tag];
    assign correct     = resolve_hit && (resolve_outcome == resolve_correct);

    // A second mispredict right behind a recovery is dropped so the
    // restore broadcast stays a single-cycle pulse
    assign mispredict  = resolve_hit && (resolve_outcome == resolve_mispredict) && !recovering;

    always_comb begin
        resolved_bit = '0;
        descendants  = '0;
        if (resolve_hit) begin
            resolved_bit[resolve_tag] = 1'b1;
        end
        // Live branches dispatched under the resolving one
        for (int i = 0; i < num_branch_tags; i++) begin
            descendants[i] = live_mask[i] && entry_dep[i][resolve_tag];
        end
    end

    always_comb begin
        if (mispredict) begin
            clear_mask = resolved_bit | descendants;
        end else if (correct) begin
            clear_mask = resolved_bit;
        end else begin
            clear_mask = '0;
        end
    end

    assign kill        = mispredict;
    assign killed_mask = kill ? clear_mask : '0;

    // Checkpoint of the resolving branch
    assign sel_pc        = entry_pc[resolve_tag];
    assign sel_rob_tail  = entry_rob_tail[resolve_tag];
    assign sel_free_list = entry_free_list[resolve_tag];
    assign sel_map_table = entry_map_table[resolve_tag];

    always_ff @(posedge clock) begin
        if (reset) begin
            recovering <= 1'b0;
            for (int i = 0; i < num_branch_tags; i++) begin
                entry_pc[i]        <= '0;
                entry_rob_tail[i]  <= '0;
                entry_free_list[i] <= '0;
                entry_map_table[i] <= '0;
                entry_dep[i]       <= '0;
            end
        end else begin
            recovering <= mispredict;
            for (int i = 0; i < num_branch_tags; i++) begin
                if (grant && (grant_tag == branch_tag_t'(i))) begin
                    entry_pc[i]        <= snap_pc;
                    entry_rob_tail[i]  <= snap_rob_tail;
                    entry_free_list[i] <= snap_free_list;
                    entry_map_table[i] <= snap_map_table;
                    entry_dep[i]       <= dispatch_mask;
                end else if (clear_mask[i]) begin
                    entry_pc[i]        <= '0;
                    entry_rob_tail[i]  <= '0;
                    entry_free_list[i] <= '0;
                    entry_map_table[i] <= '0;
                    entry_dep[i]       <= '0;
                end else begin
                    // Survivors forget released branches
                    entry_dep[i] <= entry_dep[i] & ~clear_mask;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/recovery_unit.sv
`timescale 1ns/100ps
`default_nettype none

module recovery_unit
    import branch_tag_pkg::*, checkpoint_pkg::*;
(
    input  wire logic         clock,
    input  wire logic         reset,
    input  wire logic         kill,
    input  wire branch_mask_t killed_mask,
    input  wire pc_t          sel_pc,
    input  wire rob_index_t   sel_rob_tail,
    input  wire free_list_t   sel_free_list,
    input  wire map_table_t   sel_map_table,
    output logic              restore_valid,
    output pc_t               restore_pc,
    output rob_index_t        restore_rob_tail,
    output free_list_t        restore_free_list,
    output map_table_t        restore_map_table,
    output branch_mask_t      squash_mask
);

    // One-cycle broadcast of the checkpoint taken at the kill
    always_ff @(posedge clock) begin
        if (reset) begin
            restore_valid     <= 1'b0;
            restore_pc        <= '0;
            restore_rob_tail  <= '0;
            restore_free_list <= '0;
            restore_map_table <= '0;
            squash_mask       <= '0;
        end else begin
            restore_valid <= kill;
            if (kill) begin
                restore_pc        <= sel_pc;
                restore_rob_tail  <= sel_rob_tail;
                restore_free_list <= sel_free_list;
                restore_map_table <= sel_map_table;
                squash_mask       <= killed_mask;
            end else begin
                // Data returns to zero between broadcasts
                restore_pc        <= '0;
                restore_rob_tail  <= '0;
                restore_free_list <= '0;
                restore_map_table <= '0;
                squash_mask       <= '0;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/branch_recovery_top.sv
`timescale 1ns/100ps
`default_nettype none

module branch_recovery_top
    import branch_tag_pkg::*, checkpoint_pkg::*;
(
    input  wire logic             clock,
    input  wire logic             reset,
    // Dispatch
    input  wire logic             branch_valid,
    input  wire pc_t              snap_pc,
    input  wire rob_index_t       snap_rob_tail,
    input  wire free_list_t       snap_free_list,
    input  wire map_table_t       snap_map_table,
    output logic                  branch_ready,
    output branch_tag_t           alloc_tag,
    output branch_mask_t          dispatch_mask,
    output branch_mask_t          live_mask,
    // Resolve
    input  wire logic             resolve_valid,
    input  wire branch_tag_t      resolve_tag,
    input  wire resolve_outcome_e resolve_outcome,
    // Restore broadcast
    output logic                  restore_valid,
    output pc_t                   restore_pc,
    output rob_index_t            restore_rob_tail,
    output free_list_t            restore_free_list,
    output map_table_t            restore_map_table,
    output branch_mask_t          squash_mask
);

    logic         grant;
    logic         kill;
    branch_mask_t clear_mask;
    branch_mask_t killed_mask;
    pc_t          sel_pc;
    rob_index_t   sel_rob_tail;
    free_list_t   sel_free_list;
    map_table_t   sel_map_table;

    tag_allocator u_tag_allocator (
        .clock         (clock),
        .reset         (reset),
        .branch_valid  (branch_valid),
        .clear_mask    (clear_mask),
        .kill          (kill),
        .branch_ready  (branch_ready),
        .grant         (grant),
        .grant_tag     (alloc_tag),
        .dispatch_mask (dispatch_mask),
        .live_mask     (live_mask)
    );

    branch_stack u_branch_stack (
        .clock           (clock),
        .reset           (reset),
        .grant           (grant),
        .grant_tag       (alloc_tag),
        .dispatch_mask   (dispatch_mask),
        .live_mask       (live_mask),
        .snap_pc         (snap_pc),
        .snap_rob_tail   (snap_rob_tail),
        .snap_free_list  (snap_free_list),
        .snap_map_table  (snap_map_table),
        .resolve_valid   (resolve_valid),
        .resolve_tag     (resolve_tag),
        .resolve_outcome (resolve_outcome),
        .clear_mask      (clear_mask),
        .kill            (kill),
        .killed_mask     (killed_mask),
        .sel_pc          (sel_pc),
        .sel_rob_tail    (sel_rob_tail),
        .sel_free_list   (sel_free_list),
        .sel_map_table   (sel_map_table)
    );

    recovery_unit u_recovery_unit (
        .clock             (clock),
        .reset             (reset),
        .kill              (kill),
        .killed_mask       (killed_mask),
        .sel_pc            (sel_pc),
        .sel_rob_tail      (sel_rob_tail),
        .sel_free_list     (sel_free_list),
        .sel_map_table     (sel_map_table),
        .restore_valid     (restore_valid),
        .restore_pc        (restore_pc),
        .restore_rob_tail  (restore_rob_tail),
        .restore_free_list (restore_free_list),
        .restore_map_table (restore_map_table),
        .squash_mask       (squash_mask)
    );

endmodule

`default_nettype wire

//--- verif/branch_recovery_sva.sv
`timescale 1ns/100ps
`default_nettype none

module branch_recovery_sva
    import branch_tag_pkg::*;
(
    input wire logic         clock,
    input wire logic         reset,
    input wire logic         branch_ready,
    input wire branch_mask_t live_mask,
    input wire logic         restore_valid,
    input wire branch_mask_t squash_mask
);

    // Number of assertion failures, read by the testbench at the end
    int failure_count = 0;

    // A restore broadcast is a single-cycle pulse
    restore_single_pulse: assert property (
        @(posedge clock) disable iff (reset) restore_valid |=> !restore_valid
    ) else begin
        failure_count++;
        $error("restore_valid stayed high for two cycles");
    end

    // Squash mask is only driven during a restore
    squash_only_on_restore: assert property (
        @(posedge clock) disable iff (reset) !restore_valid |-> (squash_mask == '0)
    ) else begin
        failure_count++;
        $error("squash_mask nonzero without restore_valid");
    end

    // No allocation when every tag is busy
    full_blocks_dispatch: assert property (
        @(posedge clock) disable iff (reset) (&live_mask) |-> !branch_ready
    ) else begin
        failure_count++;
        $error("branch_ready high with all tags busy");
    end

endmodule

bind branch_recovery_top branch_recovery_sva u_sva (
    .clock         (clock),
    .reset         (reset),
    .branch_ready  (branch_ready),
    .live_mask     (live_mask),
    .restore_valid (restore_valid),
    .squash_mask   (squash_mask)
);

`default_nettype wire

//--- verif/branch_recovery_tb.sv
`timescale 1ns/100ps
`default_nettype none

module branch_recovery_tb
    import branch_tag_pkg::*, checkpoint_pkg::*;
();

    localparam int clock_period  = 4;
    localparam int reset_cycles  = 4;
    localparam int num_cycles    = 3000;
    localparam int margin_cycles = 200;

    logic             clock;
    logic             reset;
    logic             branch_valid;
    pc_t              snap_pc;
    rob_index_t       snap_rob_tail;
    free_list_t       snap_free_list;
    map_table_t       snap_map_table;
    logic             branch_ready;
    branch_tag_t      alloc_tag;
    branch_mask_t     dispatch_mask;
    branch_mask_t     live_mask;
    logic             resolve_valid;
    branch_tag_t      resolve_tag;
    resolve_outcome_e resolve_outcome;
    logic             restore_valid;
    pc_t              restore_pc;
    rob_index_t       restore_rob_tail;
    free_list_t       restore_free_list;
    map_table_t       restore_map_table;
    branch_mask_t     squash_mask;

    // Reference model: busy set and one checkpoint per tag
    branch_mask_t m_busy;
    pc_t          m_pc        [num_branch_tags];
    rob_index_t   m_rob_tail  [num_branch_tags];
    free_list_t   m_free_list [num_branch_tags];
    map_table_t   m_map_table [num_branch_tags];
    branch_mask_t m_dep       [num_branch_tags];
    logic         m_recovering;

    // Expected restore outputs for the next cycle
    logic         exp_restore_valid;
    pc_t          exp_restore_pc;
    rob_index_t   exp_restore_rob_tail;
    free_list_t   exp_restore_free_list;
    map_table_t   exp_restore_map_table;
    branch_mask_t exp_squash_mask;

    logic [31:0] lcg_state = 32'hf706_a43d;
    int          grant_count = 0;
    int          mispredict_count = 0;

    branch_recovery_top dut (.*);

    initial begin
        clock = 1'b0;
        forever #(clock_period / 2) clock = ~clock;
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic stop_with_failure(string reason);
        $display("%s", reason);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic compare_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("Fail %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic compare_mask(string name, branch_mask_t got, branch_mask_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("Fail %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic compare_tag(string name, branch_tag_t got, branch_tag_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("Fail %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic compare_pc(string name, pc_t got, pc_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("Fail %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic compare_rob_tail(string name, rob_index_t got, rob_index_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("Fail %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic compare_free_list(string name, free_list_t got, free_list_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("Fail %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic compare_map_table(string name, map_table_t got, map_table_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("Fail %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    // Drive one cycle, check every output against the model, then advance the model
    task automatic run_cycle(logic bv, logic rv, branch_tag_t rt, resolve_outcome_e ro);
        logic         hit;
        logic         mispredict;
        logic         exp_ready;
        logic         found;
        logic         granted;
        branch_tag_t  exp_tag;
        branch_mask_t released;
        branch_mask_t surviving;
        map_table_t   snap_map;
        @(posedge clock);
        #1;
        for (int a = 0; a < num_arch_regs; a++) begin
            snap_map[a] = phys_reg_idx_t'(next_random() >> 11);
        end
        branch_valid    = bv;
        snap_pc         = next_random();
        snap_rob_tail   = rob_index_t'(next_random() >> 20);
        snap_free_list  = next_random();
        snap_map_table  = snap_map;
        resolve_valid   = rv;
        resolve_tag     = rt;
        resolve_outcome = ro;

        // Free tag resolves and a mispredict right behind a recovery do nothing
        hit        = rv && m_busy[rt];
        mispredict = hit && (ro == resolve_mispredict) && !m_recovering;
        released   = '0;
        if (mispredict || (hit && ro == resolve_correct)) begin
            released[rt] = 1'b1;
        end
        for (int i = 0; i < num_branch_tags; i++) begin
            if (mispredict && m_busy[i] && m_dep[i][rt]) begin
                released[i] = 1'b1;
            end
        end
        surviving = m_busy & ~released;
        exp_ready = (m_busy != '1) && !mispredict;
        found     = 1'b0;
        exp_tag   = '0;
        for (int i = 0; i < num_branch_tags; i++) begin
            if (!found && !surviving[i]) begin
                exp_tag = branch_tag_t'(i);
                found   = 1'b1;
            end
        end
        granted = bv && exp_ready;

        #2;
        compare_bit("branch_ready", branch_ready, exp_ready);
        compare_mask("live_mask", live_mask, m_busy);
        compare_mask("dispatch_mask", dispatch_mask, surviving);
        if (found) begin
            compare_tag("alloc_tag", alloc_tag, exp_tag);
        end
        compare_bit("restore_valid", restore_valid, exp_restore_valid);
        compare_pc("restore_pc", restore_pc, exp_restore_pc);
        compare_rob_tail("restore_rob_tail", restore_rob_tail, exp_restore_rob_tail);
        compare_free_list("restore_free_list", restore_free_list, exp_restore_free_list);
        compare_map_table("restore_map_table", restore_map_table, exp_restore_map_table);
        compare_mask("squash_mask", squash_mask, exp_squash_mask);

        // Restore data is the checkpoint as it was before this edge
        exp_restore_valid     = mispredict;
        exp_restore_pc        = mispredict ? m_pc[rt] : '0;
        exp_restore_rob_tail  = mispredict ? m_rob_tail[rt] : '0;
        exp_restore_free_list = mispredict ? m_free_list[rt] : '0;
        exp_restore_map_table = mispredict ? m_map_table[rt] : '0;
        exp_squash_mask       = mispredict ? released : '0;

        for (int i = 0; i < num_branch_tags; i++) begin
            if (granted && exp_tag == branch_tag_t'(i)) begin
                m_pc[i]        = snap_pc;
                m_rob_tail[i]  = snap_rob_tail;
                m_free_list[i] = snap_free_list;
                m_map_table[i] = snap_map_table;
                m_dep[i]       = surviving;
            end else if (released[i]) begin
                m_pc[i]        = '0;
                m_rob_tail[i]  = '0;
                m_free_list[i] = '0;
                m_map_table[i] = '0;
                m_dep[i]       = '0;
            end else begin
                m_dep[i] = m_dep[i] & ~released;
            end
        end
        m_busy = surviving;
        if (granted) begin
            m_busy[exp_tag] = 1'b1;
            grant_count++;
        end
        m_recovering = mispredict;
        if (mispredict) begin
            mispredict_count++;
        end
    endtask

    initial begin : watchdog
        #((num_cycles + margin_cycles) * clock_period);
        stop_with_failure("Timeout: the test did not reach its end in time");
    end

    initial begin
        logic             bv;
        logic             rv;
        branch_tag_t      rt;
        resolve_outcome_e ro;
        logic [31:0]      r;
        reset           = 1'b1;
        branch_valid    = 1'b0;
        snap_pc         = '0;
        snap_rob_tail   = '0;
        snap_free_list  = '0;
        snap_map_table  = '0;
        resolve_valid   = 1'b0;
        resolve_tag     = '0;
        resolve_outcome = resolve_correct;
        m_busy          = '0;
        m_recovering    = 1'b0;
        for (int i = 0; i < num_branch_tags; i++) begin
            m_pc[i]        = '0;
            m_rob_tail[i]  = '0;
            m_free_list[i] = '0;
            m_map_table[i] = '0;
            m_dep[i]       = '0;
        end
        exp_restore_valid     = 1'b0;
        exp_restore_pc        = '0;
        exp_restore_rob_tail  = '0;
        exp_restore_free_list = '0;
        exp_restore_map_table = '0;
        exp_squash_mask       = '0;

        repeat (reset_cycles) @(posedge clock);
        #1;
        reset = 1'b0;
        #2;
        compare_bit("branch_ready", branch_ready, 1'b1);
        compare_mask("live_mask", live_mask, '0);
        compare_bit("restore_valid", restore_valid, 1'b0);

        // Fill all tags with no resolves, then one more dispatch is refused
        repeat (num_branch_tags) run_cycle(1'b1, 1'b0, '0, resolve_correct);
        run_cycle(1'b1, 1'b0, '0, resolve_correct);
        compare_bit("branch_ready", branch_ready, 1'b0);

        // Reuse tag 0 after a correct resolve, then mispredict only the new branch
        run_cycle(1'b0, 1'b1, 2'd0, resolve_correct);
        run_cycle(1'b1, 1'b0, '0, resolve_correct);
        run_cycle(1'b0, 1'b1, 2'd0, resolve_mispredict);
        run_cycle(1'b0, 1'b0, '0, resolve_correct);

        // Dispatch with a mispredict is dropped
        run_cycle(1'b1, 1'b1, 2'd1, resolve_mispredict);
        run_cycle(1'b1, 1'b0, '0, resolve_correct);

        // A mispredict of a free tag gives no restore and keeps the live tag
        run_cycle(1'b0, 1'b1, 2'd1, resolve_mispredict);
        run_cycle(1'b0, 1'b0, '0, resolve_correct);

        repeat (num_cycles) begin
            r  = next_random();
            bv = ((r >> 16) % 100) < 60;
            r  = next_random();
            rv = ((r >> 16) % 100) < 40;
            ro = r[5] ? resolve_mispredict : resolve_correct;
            rt = branch_tag_t'(r >> 28);
            // Three in four resolves walk to the next live tag
            if (r[8] || r[9]) begin
                for (int k = 0; k < num_branch_tags; k++) begin
                    if (!m_busy[rt]) begin
                        rt = rt + 1'b1;
                    end
                end
            end
            run_cycle(bv, rv, rt, ro);
        end

        if (dut.u_sva.failure_count == 0) begin
            $display("grants %0d, mispredicts %0d", grant_count, mispredict_count);
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            stop_with_failure("A concurrent assertion on the DUT outputs failed");
        end
    end

endmodule

`default_nettype wire

//--- project.f
logic/branch_tag_pkg.sv
logic/checkpoint_pkg.sv
logic/tag_allocator.sv
logic/branch_stack.sv
logic/recovery_unit.sv
logic/branch_recovery_top.sv
verif/branch_recovery_sva.sv
verif/branch_recovery_tb.sv
